// ==== rtl/mem_pkg.sv ====
// memory subsystem package
// word address split, cache geometry and main memory constants
// shared by both caches, the fill sequencer and main memory
package mem_pkg;

	localparam int ADDR_W = 16;                         // word address width
	localparam int DATA_W = 16;                         // data word width
	localparam int OFFSET_W = 3;                        // word inside a block
	localparam int INDEX_W = 5;                         // line select
	localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W; // whatever is left over
	localparam int WORDS_PER_BLOCK = 1 << OFFSET_W;     // words fetched per fill
	localparam int NUM_LINES = 1 << INDEX_W;            // lines per cache
	localparam int CACHE_WORDS = NUM_LINES * WORDS_PER_BLOCK;
	localparam int MEM_WORDS = 1 << ADDR_W;             // full 64K word space
	localparam int MEM_LATENCY = 4;                     // read request to data valid

	// power-up image of main memory is addr ^ key
	localparam logic [DATA_W-1:0] MEM_INIT_KEY = 16'h5a5a;

	// cache view of a word address
	typedef struct packed {
		logic [TAG_W-1:0]    tag;
		logic [INDEX_W-1:0]  index;
		logic [OFFSET_W-1:0] offset;
	} addr_fields_t;

	// one address word seen either raw or split into fields
	typedef union packed {
		logic [ADDR_W-1:0] raw;
		addr_fields_t      f;
	} word_addr_t;

endpackage

// ==== rtl/cache.sv ====
// direct-mapped cache
// 32 lines of 8 words, one tag and valid bit per line
// hit and read data are combinational from the address,
// stores update the word only on a hit, the fill port writes
// returned words and finally the tag
`timescale 1ns/1ps

module cache (
	input  logic                        clk,
	input  logic                        rst_n,
	input  mem_pkg::word_addr_t         addr,         // lookup address
	input  logic                        wr_en,        // store from the pipeline
	input  logic [mem_pkg::DATA_W-1:0]  wdata,
	input  logic                        fill_data_we, // fill word strobe
	input  logic                        fill_tag_we,  // fill done, set tag and valid
	input  mem_pkg::word_addr_t         fill_addr,
	input  logic [mem_pkg::DATA_W-1:0]  fill_data,
	output logic                        hit,
	output logic [mem_pkg::DATA_W-1:0]  rdata
);
	import mem_pkg::*;

	logic [NUM_LINES-1:0] valid;                // cleared by reset
	logic [TAG_W-1:0]     tag_mem [NUM_LINES];
	logic [DATA_W-1:0]    data_mem [CACHE_WORDS];

	logic [INDEX_W+OFFSET_W-1:0] rd_word;       // {index, offset} of lookup
	logic [INDEX_W+OFFSET_W-1:0] fill_word;     // {index, offset} of fill

	assign rd_word = {addr.f.index, addr.f.offset};
	assign fill_word = {fill_addr.f.index, fill_addr.f.offset};

	// tag compare against the selected line
	assign hit = valid[addr.f.index] && (tag_mem[addr.f.index] == addr.f.tag);
	assign rdata = data_mem[rd_word]; // meaningful only with hit

	// data array
	// fill has priority, a store never overlaps a fill anyway
	always_ff @(posedge clk) begin
		if (fill_data_we) begin
			data_mem[fill_word] <= fill_data;
		end else if (wr_en && hit) begin
			data_mem[rd_word] <= wdata; // write-through hit, no allocate on miss
		end
	end

	// tag array
	always_ff @(posedge clk) begin
		if (fill_tag_we) begin
			tag_mem[fill_addr.f.index] <= fill_addr.f.tag;
		end
	end

	// valid bits
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid <= '0;
		end else if (fill_tag_we) begin
			valid[fill_addr.f.index] <= 1'b1; // line usable from next cycle
		end
	end

endmodule

// ==== rtl/cache_fill_fsm.sv ====
// cache block fill sequencer
// issues one pipelined memory read per cycle for the 8 words of a block,
// writes each word into the cache as it returns, then writes the tag
// shared by both caches, the controller picks the target
`timescale 1ns/1ps

module cache_fill_fsm (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        fill_start,      // only looked at while idle
	input  mem_pkg::word_addr_t         fill_addr,       // missing address
	input  logic [mem_pkg::DATA_W-1:0]  mem_rdata,
	input  logic                        mem_rdata_valid,
	output logic                        busy,
	output logic                        mem_rd,
	output logic [mem_pkg::ADDR_W-1:0]  mem_addr,
	output logic                        data_we,         // word_data goes to word_addr
	output logic                        tag_we,          // last fill cycle
	output mem_pkg::word_addr_t         word_addr,
	output logic [mem_pkg::DATA_W-1:0]  word_data
);
	import mem_pkg::*;

	word_addr_t          base;       // block being filled
	word_addr_t          issue_addr;
	logic                issuing;    // read requests still going out
	logic [OFFSET_W-1:0] issue_cnt;  // offset of next read request
	logic [OFFSET_W-1:0] ret_cnt;    // offset of next returning word
	logic                accept;
	logic                last_issue;
	logic                last_ret;

	assign accept = fill_start && !busy;
	assign last_issue = issue_cnt == OFFSET_W'(WORDS_PER_BLOCK - 1);
	assign last_ret = data_we && (ret_cnt == OFFSET_W'(WORDS_PER_BLOCK - 1));

	// request and return addresses share tag and index of the block
	always_comb begin
		issue_addr = base;
		issue_addr.f.offset = issue_cnt;
		word_addr = base;
		word_addr.f.offset = ret_cnt; // wraps to 0 for the tag cycle
	end

	assign mem_rd = issuing;
	assign mem_addr = issue_addr.raw;
	assign data_we = busy && mem_rdata_valid; // memory only returns fill reads
	assign word_data = mem_rdata;

	// control
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			issuing <= 1'b0;
			tag_we <= 1'b0;
			issue_cnt <= '0;
			ret_cnt <= '0;
		end else begin
			if (accept) begin
				busy <= 1'b1;
				issuing <= 1'b1; // first read goes out next cycle
				issue_cnt <= '0;
				ret_cnt <= '0;
			end
			if (issuing) begin
				issue_cnt <= issue_cnt + 1'b1;
				if (last_issue)
					issuing <= 1'b0;
			end
			if (data_we)
				ret_cnt <= ret_cnt + 1'b1;
			if (last_ret)
				tag_we <= 1'b1; // tag goes in the cycle after the 8th word
			if (tag_we) begin
				tag_we <= 1'b0;
				busy <= 1'b0; // back to idle
			end
		end
	end

	// block base, payload only
	always_ff @(posedge clk) begin
		if (accept)
			base <= fill_addr;
	end

endmodule

// ==== rtl/main_memory.sv ====
// main memory model
// 64K words, one-cycle writes, reads pipelined over a fixed latency
// so a new read can be issued every cycle
// contents start as address xor a fixed key
`timescale 1ns/1ps

module main_memory (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        rd,          // read request
	input  logic                        wr,          // write request
	input  logic [mem_pkg::ADDR_W-1:0]  addr,
	input  logic [mem_pkg::DATA_W-1:0]  wdata,
	output logic [mem_pkg::DATA_W-1:0]  rdata,
	output logic                        rdata_valid  // MEM_LATENCY cycles after rd
);
	import mem_pkg::*;

	logic [DATA_W-1:0]      mem [MEM_WORDS];
	logic [MEM_LATENCY-1:0] rd_vld;               // one bit per pipeline stage
	logic [ADDR_W-1:0]      rd_addr [MEM_LATENCY]; // address carried along

	// power-up image, not touched by reset
	initial begin
		for (int a = 0; a < MEM_WORDS; a++)
			mem[a] = ADDR_W'(a) ^ MEM_INIT_KEY;
	end

	always @(posedge clk) begin
		if (wr)
			mem[addr] <= wdata;
	end

	// valid bits of the read pipeline
	always_ff @(posedge clk) begin
		if (!rst_n)
			rd_vld <= '0;
		else
			rd_vld <= {rd_vld[MEM_LATENCY-2:0], rd};
	end

	always_ff @(posedge clk) begin
		rd_addr[0] <= addr;
		for (int i = 1; i < MEM_LATENCY; i++)
			rd_addr[i] <= rd_addr[i-1];
	end

	// array read at the final stage
	assign rdata = mem[rd_addr[MEM_LATENCY-1]];
	assign rdata_valid = rd_vld[MEM_LATENCY-1];

endmodule

// ==== rtl/memory_controller.sv ====
// memory controller top level
// IF and DM ports each go through their own direct-mapped cache
// a read miss stalls the port and starts a shared block fill from
// main memory, IF wins when both miss at once
// DM writes go straight through to memory and update the D-cache on a hit
`timescale 1ns/1ps

module memory_controller (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        if_req,
	input  mem_pkg::word_addr_t         if_addr,
	input  logic                        dm_req,
	input  logic                        dm_we,
	input  mem_pkg::word_addr_t         dm_addr,
	input  logic [mem_pkg::DATA_W-1:0]  dm_wdata,
	output logic [mem_pkg::DATA_W-1:0]  if_rdata,
	output logic [mem_pkg::DATA_W-1:0]  dm_rdata,
	output logic                        if_miss,   // stall the fetch stage
	output logic                        dm_miss    // stall the memory stage
);
	import mem_pkg::*;

	logic              i_hit;
	logic              d_hit;
	logic              if_rd_miss;      // IF lookup missed
	logic              dm_rd_miss;      // DM load missed
	logic              fill_start;
	logic              fill_owner;      // 1 while IF owns the fill
	logic              fill_busy;
	word_addr_t        fill_addr;
	logic              fill_data_we;
	logic              fill_tag_we;
	word_addr_t        fill_word_addr;
	logic [DATA_W-1:0] fill_word_data;
	logic              fsm_mem_rd;
	logic [ADDR_W-1:0] fsm_mem_addr;
	logic              mem_wr;
	logic [ADDR_W-1:0] mem_addr;
	logic [DATA_W-1:0] mem_rdata;
	logic              mem_rdata_valid;

	assign if_rd_miss = if_req && !i_hit;
	assign dm_rd_miss = dm_req && !dm_we && !d_hit;

	// IF is also held while its own block is still coming in
	assign if_miss = if_req && (!i_hit || (fill_busy && fill_owner));
	// any DM access waits out a fill, memory is not free
	assign dm_miss = dm_req && (fill_busy || (!dm_we && !d_hit));

	// arbitration, IF first
	assign fill_start = !fill_busy && (if_rd_miss || dm_rd_miss);
	assign fill_addr = if_rd_miss ? if_addr : dm_addr;

	always_ff @(posedge clk) begin
		if (!rst_n)
			fill_owner <= 1'b0;
		else if (fill_start)
			fill_owner <= if_rd_miss;
	end

	// write-through, one cycle when memory is idle
	assign mem_wr = dm_req && dm_we && !fill_busy;
	assign mem_addr = fsm_mem_rd ? fsm_mem_addr : dm_addr.raw; // fill reads own the bus

	cache i_cache_i (
		.clk(clk), .rst_n(rst_n), .addr(if_addr),
		.wr_en(1'b0), .wdata('0), // no stores on the fetch side
		.fill_data_we(fill_data_we && fill_owner), .fill_tag_we(fill_tag_we && fill_owner),
		.fill_addr(fill_word_addr), .fill_data(fill_word_data),
		.hit(i_hit), .rdata(if_rdata)
	);

	cache d_cache_i (
		.clk(clk), .rst_n(rst_n), .addr(dm_addr),
		.wr_en(mem_wr), .wdata(dm_wdata),
		.fill_data_we(fill_data_we && !fill_owner), .fill_tag_we(fill_tag_we && !fill_owner),
		.fill_addr(fill_word_addr), .fill_data(fill_word_data),
		.hit(d_hit), .rdata(dm_rdata)
	);

	cache_fill_fsm fill_fsm_i (
		.clk(clk), .rst_n(rst_n), .fill_start(fill_start), .fill_addr(fill_addr),
		.mem_rdata(mem_rdata), .mem_rdata_valid(mem_rdata_valid),
		.busy(fill_busy), .mem_rd(fsm_mem_rd), .mem_addr(fsm_mem_addr),
		.data_we(fill_data_we), .tag_we(fill_tag_we),
		.word_addr(fill_word_addr), .word_data(fill_word_data)
	);

	main_memory main_memory_i (
		.clk(clk), .rst_n(rst_n), .rd(fsm_mem_rd), .wr(mem_wr),
		.addr(mem_addr), .wdata(dm_wdata),
		.rdata(mem_rdata), .rdata_valid(mem_rdata_valid)
	);

endmodule

// ==== test/memory_controller_tb.sv ====
// testbench for the memory controller
// directed hit, miss, conflict, write-through and stall tests,
// then a random mix, all checked against a word model of memory
`timescale 1ns/1ps

module memory_controller_tb;
	import mem_pkg::*;

	localparam int DIRECTED_ACCESSES = 19;  // port accesses in the directed tests
	localparam int NUM_RANDOM = 200;
	localparam int TIMEOUT_CYCLES = 40 * (DIRECTED_ACCESSES + NUM_RANDOM);

	logic              clk;
	logic              rst_n;
	logic              if_req;
	word_addr_t        if_addr;
	logic              dm_req;
	logic              dm_we;
	word_addr_t        dm_addr;
	logic [DATA_W-1:0] dm_wdata;
	logic [DATA_W-1:0] if_rdata;
	logic [DATA_W-1:0] dm_rdata;
	logic              if_miss;
	logic              dm_miss;

	logic [DATA_W-1:0] model [MEM_WORDS]; // expected memory image
	int                error_count = 0;
	int                cycle_count = 0;
	int                seed = 32'h42a4bb8f;

	memory_controller dut_i (
		.clk(clk), .rst_n(rst_n),
		.if_req(if_req), .if_addr(if_addr),
		.dm_req(dm_req), .dm_we(dm_we), .dm_addr(dm_addr), .dm_wdata(dm_wdata),
		.if_rdata(if_rdata), .dm_rdata(dm_rdata),
		.if_miss(if_miss), .dm_miss(dm_miss)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	// run limit, scaled to the number of accesses
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: a miss never cleared within %0d cycles", TIMEOUT_CYCLES);
			$display("Done: errors found");
			$fatal(1, "simulation stopped by timeout");
		end
	end

	task automatic check(input string name, input logic [DATA_W-1:0] got,
			input logic [DATA_W-1:0] expected);
		if (got !== expected) begin
			error_count++;
			$display("MISMATCH %s: got %h expected %h", name, got, expected);
			$display("Done: errors found");
			$fatal(1, "stopping on first error");
		end
	endtask

	// fetch one word, stalls counts cycles with if_miss high
	task automatic if_read(input logic [ADDR_W-1:0] a, output int stalls);
		@(posedge clk);
		#2;
		if_req = 1'b1;
		if_addr.raw = a;
		stalls = 0;
		@(negedge clk);
		while (if_miss) begin
			stalls++;
			@(negedge clk);
		end
		check("if_rdata", if_rdata, model[a]); // accepted at the coming edge
		@(posedge clk);
		#2;
		if_req = 1'b0;
	endtask

	task automatic dm_read(input logic [ADDR_W-1:0] a, output int stalls);
		@(posedge clk);
		#2;
		dm_req = 1'b1;
		dm_we = 1'b0;
		dm_addr.raw = a;
		stalls = 0;
		@(negedge clk);
		while (dm_miss) begin
			stalls++;
			@(negedge clk);
		end
		check("dm_rdata", dm_rdata, model[a]);
		@(posedge clk);
		#2;
		dm_req = 1'b0;
	endtask

	task automatic dm_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
			output int stalls);
		@(posedge clk);
		#2;
		dm_req = 1'b1;
		dm_we = 1'b1;
		dm_addr.raw = a;
		dm_wdata = d;
		stalls = 0;
		@(negedge clk);
		while (dm_miss) begin
			stalls++; // held back by a fill
			@(negedge clk);
		end
		model[a] = d;
		@(posedge clk);
		#2;
		dm_req = 1'b0;
		dm_we = 1'b0;
	endtask

	// both ports request in the same cycle, IF must come back first
	task automatic dual_read(input logic [ADDR_W-1:0] ia, input logic [ADDR_W-1:0] da);
		int cyc;
		int if_at;
		int dm_at;
		bit if_done;
		bit dm_done;
		cyc = 0;
		if_at = 0;
		dm_at = 0;
		if_done = 1'b0;
		dm_done = 1'b0;
		@(posedge clk);
		#2;
		if_req = 1'b1;
		if_addr.raw = ia;
		dm_req = 1'b1;
		dm_we = 1'b0;
		dm_addr.raw = da;
		while (!(if_done && dm_done)) begin
			@(negedge clk);
			cyc++;
			if (!if_done && !if_miss) begin
				check("if_rdata", if_rdata, model[ia]);
				if_at = cyc;
				if_done = 1'b1;
			end
			if (!dm_done && !dm_miss) begin
				check("dm_rdata", dm_rdata, model[da]);
				dm_at = cyc;
				dm_done = 1'b1;
			end
			@(posedge clk);
			#2;
			if (if_done)
				if_req = 1'b0; // drop each port once served
			if (dm_done)
				dm_req = 1'b0;
		end
		check("if_before_dm", if_at < dm_at, 1'b1);
	endtask

	initial begin
		int s_if;
		int s_dm;
		int r;
		logic [5:0] blk;
		logic [ADDR_W-1:0] a;
		logic [DATA_W-1:0] d;
		for (int i = 0; i < MEM_WORDS; i++)
			model[i] = ADDR_W'(i) ^ MEM_INIT_KEY; // same image as power-up memory
		rst_n = 1'b0;
		if_req = 1'b0;
		if_addr = '0;
		dm_req = 1'b0;
		dm_we = 1'b0;
		dm_addr = '0;
		dm_wdata = '0;
		repeat (10) @(posedge clk);
		#2;
		rst_n = 1'b1;

		// cold misses, then another word of the same block hits at once
		if_read(16'h0123, s_if);
		check("if_miss_cold", s_if != 0, 1'b1);
		if_read(16'h0125, s_if);
		check("if_miss_warm", s_if != 0, 1'b0);
		dm_read(16'h0349, s_dm);
		check("dm_miss_cold", s_dm != 0, 1'b1);
		dm_read(16'h034e, s_dm);
		check("dm_miss_warm", s_dm != 0, 1'b0);

		dual_read(16'h0562, 16'h0784);

		// same index, other tag evicts the line
		if_read(16'h0023, s_if);
		check("if_miss_conflict", s_if != 0, 1'b1);
		if_read(16'h0123, s_if);
		check("if_miss_reload", s_if != 0, 1'b1);
		dm_read(16'h0249, s_dm);
		check("dm_miss_conflict", s_dm != 0, 1'b1);
		dm_read(16'h0349, s_dm);
		check("dm_miss_reload", s_dm != 0, 1'b1);

		// write-through on a hit, seen by DM and later by IF from memory
		dm_write(16'h034a, 16'hbeef, s_dm);
		check("dm_miss_write", s_dm != 0, 1'b0);
		dm_read(16'h034a, s_dm);
		check("dm_miss_after_write", s_dm != 0, 1'b0);
		if_read(16'h024a, s_if);
		if_read(16'h034a, s_if);
		check("if_miss_after_evict", s_if != 0, 1'b1);
		// no allocate on a write miss
		dm_write(16'h0a10, 16'h1234, s_dm);
		check("dm_miss_write_cold", s_dm != 0, 1'b0);
		dm_read(16'h0a10, s_dm);
		check("dm_miss_read_cold", s_dm != 0, 1'b1);

		// a store issued during an IF fill waits for memory
		fork
			if_read(16'h0c03, s_if);
			begin
				@(posedge clk);
				dm_write(16'h0e05, 16'hc0de, s_dm);
			end
		join
		check("dm_miss_behind_fill", s_dm != 0, 1'b1);
		dm_read(16'h0e05, s_dm);

		// 64 blocks over 8 lines per region, so hits and conflicts both happen
		// fetches stay out of the data region, the I-cache never sees stores
		for (int n = 0; n < NUM_RANDOM; n++) begin
			r = $random(seed);
			blk = r[8:3];
			a = {5'd0, blk[5:3], 2'd0, blk[2:0], r[2:0]};
			case (r[13:12])
				2'd0: if_read(a, s_if);
				2'd1, 2'd2: dm_read(a | 16'h8000, s_dm);
				default: begin
					d = DATA_W'($random(seed));
					dm_write(a | 16'h8000, d, s_dm);
				end
			endcase
		end

		if (error_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// ==== memory_controller.f ====
rtl/mem_pkg.sv
rtl/cache.sv
rtl/cache_fill_fsm.sv
rtl/main_memory.sv
rtl/memory_controller.sv
test/memory_controller_tb.sv

// ==== Makefile ====
# Verilator build and run of the memory controller testbench
VERILATOR ?= verilator
TOP       ?= memory_controller_tb
FILELIST  ?= memory_controller.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Done: no errors

.PHONY: sim clean

# pass only when the run prints the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
